//--- Bender.yml
package:
  name: lsu

sources:
  - hw/lsuPkg.sv
  - hw/busSequencer.sv
  - hw/storeDataPath.sv
  - hw/loadDataPath.sv
  - hw/lsuTop.sv
  - target: simulation
    files:
      - bench/lsuTop_assertions.sv
      - bench/lsuTb.sv

//--- bench/lsuTb.sv
// Testbench with clock, memory model, LFSR, reference model, tests and result checker
`timescale 1ns/10ps

module lsuTb;

  logic clk;
  logic rst;
  logic reqValid;
  lsuPkg::lsuReq_t req;
  logic done, fault, busy, busReady;
  logic [31:0] loadData, busRdata;
  lsuPkg::busReq_t bus;

  logic [31:0] lfsr = 32'h5a5d7085;
  logic [7:0]  memBytes [0:63];  // Memory model, 16 words
  logic [7:0]  shadow [0:63];    // Reference copy
  logic [31:0] lastData = '0;    // Expected held loadData
  int transfers = 0;
  int errors = 0;
  int testsRun = 0;
  int testsFailed = 0;
  int waitLeft;
  bit beatActive = 0;
  bit hung = 0;                  // A test never saw done
  string nameQ[$];
  logic  expFaultQ[$];
  logic [31:0] expDataQ[$];

  lsuTop u_lsuTop (.*);

  bind lsuTop lsuTop_assertions u_lsuTopAssertions (.*);

  initial begin
    clk = 0;
    forever #50 clk = ~clk;
  end

  //////////////////////
  // Helpers
  //////////////////////
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    logic b;
    v = '0;
    for (int i = 0; i < n; i++) begin
      b = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // Taps 32,22,2,1
      lfsr = {lfsr[30:0], b};
      v = {v[30:0], b};
    end
    return v;
  endfunction

  function automatic lsuPkg::lsuReq_t mkReq(input lsuPkg::memOp_t op, input lsuPkg::memSize_t sz,
                                            input logic uns, input logic be,
                                            input logic [31:0] addr, input logic [31:0] wd);
    return '{op: op, size: sz, unsignedLoad: uns, bigEndian: be, addr: addr, wdata: wd};
  endfunction

  // Value of n bytes starting at a, in the given byte order
  function automatic logic [31:0] getVal(input int a, input int n, input logic be);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v |= 32'(shadow[a+i]) << (8 * (be ? n - 1 - i : i));
    return v;
  endfunction

  function automatic void putVal(input int a, input int n, input logic be, input logic [31:0] v);
    for (int i = 0; i < n; i++) shadow[a+i] = v >> (8 * (be ? n - 1 - i : i));
  endfunction

  // Expected {fault, loadData}; updates the shadow memory
  function automatic logic [32:0] refModel(input lsuPkg::lsuReq_t r);
    int a, n;
    bit amo;
    logic [31:0] oldV, newV;
    a = r.addr[5:0];
    amo = !(r.op inside {lsuPkg::opLoad, lsuPkg::opStore});
    n = (amo || r.size == lsuPkg::sizeWord) ? 4 : (r.size == lsuPkg::sizeHalf) ? 2 : 1;
    if ((n == 2 && a[0]) || (n == 4 && a[1:0] != 0)) return {1'b1, lastData};
    oldV = getVal(a, n, r.bigEndian);
    case (r.op)
      lsuPkg::opLoad: begin
        if (n == 1 && !r.unsignedLoad) lastData = {{24{oldV[7]}}, oldV[7:0]};
        else if (n == 2 && !r.unsignedLoad) lastData = {{16{oldV[15]}}, oldV[15:0]};
        else lastData = oldV;
      end
      lsuPkg::opStore: putVal(a, n, r.bigEndian, r.wdata);
      default: begin
        case (r.op)
          lsuPkg::opAmoAdd: newV = oldV + r.wdata;
          lsuPkg::opAmoAnd: newV = oldV & r.wdata;
          lsuPkg::opAmoOr:  newV = oldV | r.wdata;
          lsuPkg::opAmoXor: newV = oldV ^ r.wdata;
          default:          newV = r.wdata;
        endcase
        putVal(a, 4, r.bigEndian, newV);
        lastData = oldV;  // Old value returned
      end
    endcase
    return {1'b0, lastData};
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expv, input logic [31:0] act);
    if (expv !== act) begin
      errors++;
      $display("Fail %s expected %h actual %h", name, expv, act);
    end
  endtask

  ////////////////////
  // Memory model
  ////////////////////
  always @(negedge clk) begin
    if (bus.valid) begin
      if (!beatActive) begin
        beatActive = 1;
        waitLeft = randBits(2);  // 0 to 3 wait states
      end
      busReady = (waitLeft == 0);
      if (waitLeft > 0) waitLeft--;
      busRdata = {memBytes[bus.addr[5:0]+3], memBytes[bus.addr[5:0]+2],
                  memBytes[bus.addr[5:0]+1], memBytes[bus.addr[5:0]]};
    end else begin
      busReady = 0;
      beatActive = 0;
    end
  end

  always @(posedge clk) begin
    if (!rst && bus.valid && busReady) begin
      transfers++;
      beatActive = 0;
      if (bus.write) begin
        for (int k = 0; k < 4; k++)
          if (bus.wstrb[k]) memBytes[bus.addr[5:0]+k] = bus.wdata[8*k +: 8];  // Lane k
      end
    end
  end

  // Result checker
  always @(negedge clk) begin
    if (!rst && done) begin
      if (nameQ.size() == 0) begin
        errors++;
        $display("Unexpected done strobe with no request outstanding");
      end else begin
        string nm;
        logic ef;
        logic [31:0] ed;
        nm = nameQ.pop_front();
        ef = expFaultQ.pop_front();
        ed = expDataQ.pop_front();
        checkValue({nm, " fault"}, 32'(ef), 32'(fault));
        checkValue({nm, " loadData"}, ed, loadData);  // Held value on stores and faults
        checkValue({nm, " done busy"}, 32'd1, 32'(busy));
      end
    end
  end

  ////////////////////
  // Tests
  ////////////////////
  task automatic runTest(input string name, input lsuPkg::lsuReq_t r, input bit spam);
    logic [32:0] res;
    int errBefore, xferBefore, cycles;
    if (hung) return;  // Unit stuck, nothing more to run
    errBefore = errors;
    xferBefore = transfers;
    res = refModel(r);
    nameQ.push_back(name);
    expFaultQ.push_back(res[32]);
    expDataQ.push_back(res[31:0]);
    @(negedge clk);
    checkValue({name, " idle busy"}, 32'd0, 32'(busy));
    reqValid = 1;
    req = r;
    @(negedge clk);
    reqValid = spam;  // Extra strobe while busy, must be dropped
    req = mkReq(lsuPkg::opStore, lsuPkg::sizeWord, 0, 0, r.addr, 32'hdeadbeef);
    cycles = 0;
    while (!done && cycles < 100) begin
      checkValue({name, " busy"}, 32'd1, 32'(busy));  // High from the cycle after acceptance
      @(negedge clk);
      reqValid = 0;
      cycles++;
    end
    reqValid = 0;
    if (!done) begin
      errors++;
      testsRun++;
      testsFailed++;
      hung = 1;
      $display("Timeout: no done strobe for test %s", name);
    end else begin
      @(posedge clk);
      for (int w = 0; w < 16; w++)
        checkValue($sformatf("%s mem[%0d]", name, w),
                   {shadow[4*w+3], shadow[4*w+2], shadow[4*w+1], shadow[4*w]},
                   {memBytes[4*w+3], memBytes[4*w+2], memBytes[4*w+1], memBytes[4*w]});
      if (res[32]) begin
        checkValue({name, " transfers"}, xferBefore, transfers);
        checkValue({name, " fault latency"}, 32'd0, cycles);  // done right after acceptance
      end
      testsRun++;
      if (errors != errBefore) testsFailed++;
      $display("Test %s: %s", name, (errors == errBefore) ? "ok" : "failed");
    end
  endtask

  initial begin
    lsuPkg::memOp_t op;
    reqValid = 0;
    req = '0;
    busReady = 0;
    busRdata = '0;
    rst = 1;
    for (int i = 0; i < 64; i++) begin
      memBytes[i] = randBits(8);
      if (i >= 16 && i < 20) memBytes[i][7] = (i == 16) || (i == 19);  // Mixed sign bits
      shadow[i] = memBytes[i];
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 0;
    // Word round trip in both byte orders
    for (int be = 0; be < 2; be++) begin
      runTest($sformatf("storeWord be%0d", be),
              mkReq(lsuPkg::opStore, lsuPkg::sizeWord, 0, be, 8 + 4*be, randBits(32)), 0);
      runTest($sformatf("loadWord be%0d", be),
              mkReq(lsuPkg::opLoad, lsuPkg::sizeWord, 0, be, 8 + 4*be, 0), 0);
    end
    // Subword loads at every aligned offset
    for (int be = 0; be < 2; be++)
      for (int u = 0; u < 2; u++)
        for (int off = 0; off < 4; off++) begin
          runTest($sformatf("loadByte be%0d u%0d off%0d", be, u, off),
                  mkReq(lsuPkg::opLoad, lsuPkg::sizeByte, u, be, 16 + off, 0), 0);
          if (off % 2 == 0)
            runTest($sformatf("loadHalf be%0d u%0d off%0d", be, u, off),
                    mkReq(lsuPkg::opLoad, lsuPkg::sizeHalf, u, be, 16 + off, 0), 0);
        end
    // Subword stores keep neighbouring bytes
    for (int be = 0; be < 2; be++)
      for (int off = 0; off < 4; off++) begin
        runTest($sformatf("storeByte be%0d off%0d", be, off),
                mkReq(lsuPkg::opStore, lsuPkg::sizeByte, 0, be, 20 + off, randBits(32)), 0);
        runTest($sformatf("storeHalf be%0d off%0d", be, off & 2),
                mkReq(lsuPkg::opStore, lsuPkg::sizeHalf, 0, be, 24 + (off & 2), randBits(32)), 0);
        runTest($sformatf("neighbours be%0d off%0d", be, off),
                mkReq(lsuPkg::opLoad, lsuPkg::sizeWord, 0, be, 20 + 4*(off & 1), 0), 0);
      end
    // Atomics in both byte orders
    for (int be = 0; be < 2; be++)
      for (int k = 0; k < 5; k++) begin
        op = lsuPkg::memOp_t'(k + 2);
        runTest($sformatf("%s be%0d", op.name(), be),
                mkReq(op, lsuPkg::sizeWord, 0, be, 32 + 4*k, randBits(32)), 0);
        runTest($sformatf("%s check be%0d", op.name(), be),
                mkReq(lsuPkg::opLoad, lsuPkg::sizeWord, 0, be, 32 + 4*k, 0), 0);
      end
    // Misaligned requests fault without bus traffic
    runTest("misalignedHalf", mkReq(lsuPkg::opLoad, lsuPkg::sizeHalf, 0, 0, 41, 0), 0);
    runTest("misalignedWord", mkReq(lsuPkg::opStore, lsuPkg::sizeWord, 0, 1, 42, 32'h1), 0);
    runTest("misalignedAmo", mkReq(lsuPkg::opAmoAdd, lsuPkg::sizeByte, 0, 0, 43, 32'h1), 0);
    // Strobe while busy is dropped
    runTest("busyIgnore", mkReq(lsuPkg::opLoad, lsuPkg::sizeWord, 0, 0, 48, 0), 1);
    runTest("afterBusy", mkReq(lsuPkg::opLoad, lsuPkg::sizeWord, 0, 1, 48, 0), 0);

    errors += u_lsuTop.u_lsuTopAssertions.failCount;  // Bus protocol failures
    $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
             testsRun, testsFailed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- bench/lsuTop_assertions.sv
// Concurrent bus-protocol and result-strobe assertions bound to the load/store unit top
`timescale 1ns/10ps

module lsuTop_assertions (
  input logic                   clk,
  input logic                   rst,
  input logic                   reqValid,
  input lsuPkg::lsuReq_t        req,
  input logic                   busy,
  input logic                   done,
  input logic                   fault,
  input lsuPkg::busReq_t        bus,
  input logic                   busReady
);

  logic badReq;         // Misaligned request seen on the core side
  int   failCount = 0;  // Count of assertion failures

  assign badReq = ((req.size == lsuPkg::sizeHalf) && req.addr[0]) ||
                  (((req.size == lsuPkg::sizeWord) || (req.op != lsuPkg::opLoad &&
                    req.op != lsuPkg::opStore)) && (req.addr[1:0] != 2'b00));

  // Beat held until ready
  busStable: assert property (@(posedge clk) disable iff (rst)
    bus.valid && !busReady |=> bus.valid && $stable(bus))
    else begin
      failCount++;
      $error("bus fields changed during a wait state");
    end

  doneOneCycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else begin
      failCount++;
      $error("done held longer than one cycle");
    end

  // Fault only with done, one cycle after a misaligned acceptance
  faultWithDone: assert property (@(posedge clk) disable iff (rst)
    fault |-> done && $past(reqValid && !busy && badReq))
    else begin
      failCount++;
      $error("fault raised without done after a misaligned request");
    end

  noBusOnFault: assert property (@(posedge clk) disable iff (rst)
    reqValid && !busy && badReq |=> !bus.valid)
    else begin
      failCount++;
      $error("bus access after a misaligned request");
    end

endmodule

//--- compile.f
hw/lsuPkg.sv
hw/busSequencer.sv
hw/storeDataPath.sv
hw/loadDataPath.sv
hw/lsuTop.sv
bench/lsuTop_assertions.sv
bench/lsuTb.sv

//--- hw/busSequencer.sv
// Request acceptance, alignment check and read/write phase sequencing for the bus
`timescale 1ns/10ps

module busSequencer (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     reqValid,
  input  lsuPkg::lsuReq_t          req,
  output lsuPkg::lsuReq_t          hold,      // Request held for the data paths
  output logic                     busValid,
  output logic                     busWrite,
  output logic [lsuPkg::XLEN-1:0]  busAddr,
  input  logic                     busReady,
  output logic                     capture,   // Read data valid on the bus this cycle
  output logic                     done,
  output logic                     fault,
  output logic                     busy
);

  lsuPkg::seqState_t  state;
  lsuPkg::seqState_t  nextState;
  logic               accept;     // Request taken this cycle
  logic               faultReg;   // Misalignment seen at acceptance

  // Halfword needs bit 0 clear, word and atomics need bits 1:0 clear
  function automatic logic misaligned(input lsuPkg::lsuReq_t r);
    logic wordLike;
    wordLike = (r.size == lsuPkg::sizeWord) || lsuPkg::isAmo(r.op);
    return (wordLike && (r.addr[1:0] != 2'b00)) ||
           ((r.size == lsuPkg::sizeHalf) && r.addr[0]);
  endfunction

  assign accept = reqValid && (state == lsuPkg::stIdle);  // Strobe ignored while busy

  //////////////////////
  // Next state
  //////////////////////
  always_comb begin
    nextState = state;
    case (state)
      lsuPkg::stIdle: begin
        if (accept) begin
          if (misaligned(req)) begin
            nextState = lsuPkg::stDone;  // Fault without touching the bus
          end else if (req.op == lsuPkg::opStore) begin
            nextState = lsuPkg::stWrite;
          end else begin
            nextState = lsuPkg::stRead;  // Loads and atomics read first
          end
        end
      end
      lsuPkg::stRead: begin
        if (busReady) begin
          // Atomics continue with the write half
          nextState = (hold.op == lsuPkg::opLoad) ? lsuPkg::stDone : lsuPkg::stWrite;
        end
      end
      lsuPkg::stWrite: begin
        if (busReady) nextState = lsuPkg::stDone;
      end
      lsuPkg::stDone:  nextState = lsuPkg::stIdle;
      default:         nextState = lsuPkg::stIdle;
    endcase
  end

  //////////////////////
  // Registers
  //////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= lsuPkg::stIdle;
      faultReg <= 1'b0;
    end else begin
      state <= nextState;
      if (accept) faultReg <= misaligned(req);  // Held until the next acceptance
    end
  end

  // Request payload
  always_ff @(posedge clk) begin
    if (accept) hold <= req;
  end

  //////////////////////
  // Outputs
  //////////////////////
  assign busValid = (state == lsuPkg::stRead) || (state == lsuPkg::stWrite);
  assign busWrite = state == lsuPkg::stWrite;
  assign busAddr  = {hold.addr[lsuPkg::XLEN-1:2], 2'b00};   // Word address only
  assign capture  = (state == lsuPkg::stRead) && busReady;  // Same cycle as read completion
  assign done     = state == lsuPkg::stDone;
  assign fault    = done && faultReg;
  assign busy     = state != lsuPkg::stIdle;                // Through the done cycle

endmodule

//--- hw/loadDataPath.sv
// Read data capture, value-order word for atomics, subword select and load extension
`timescale 1ns/10ps

module loadDataPath (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     capture,   // Read beat completes
  input  logic [lsuPkg::XLEN-1:0]  busRdata,
  input  lsuPkg::lsuReq_t          hold,
  output logic [lsuPkg::XLEN-1:0]  oldWord,   // Captured word in value order
  output logic [lsuPkg::XLEN-1:0]  loadData
);

  logic [lsuPkg::XLEN-1:0] rawWord;  // Bus word, lanes by address

  // Pick and extend the addressed bytes of a lane-ordered word
  function automatic logic [lsuPkg::XLEN-1:0] extract(input logic [lsuPkg::XLEN-1:0] raw,
                                                      input lsuPkg::lsuReq_t r);
    logic [7:0]               byteVal;
    logic [7:0]               loLane;   // Lower addressed lane of the halfword
    logic [7:0]               hiLane;
    logic [15:0]              halfVal;
    logic [lsuPkg::XLEN-1:0]  wordVal;
    byteVal = raw[{r.addr[1:0], 3'b000} +: 8];
    loLane  = raw[{r.addr[1], 4'b0000} +: 8];
    hiLane  = raw[{r.addr[1], 4'b1000} +: 8];
    halfVal = r.bigEndian ? {loLane, hiLane} : {hiLane, loLane};  // MSB lane by byte order
    wordVal = r.bigEndian ? lsuPkg::byteSwap(raw) : raw;
    if (lsuPkg::isAmo(r.op)) return wordVal;  // Old value, full word
    case (r.size)
      lsuPkg::sizeByte:
        return r.unsignedLoad ? {{(lsuPkg::XLEN-8){1'b0}}, byteVal}
                              : {{(lsuPkg::XLEN-8){byteVal[7]}}, byteVal};
      lsuPkg::sizeHalf:
        return r.unsignedLoad ? {{(lsuPkg::XLEN-16){1'b0}}, halfVal}
                              : {{(lsuPkg::XLEN-16){halfVal[15]}}, halfVal};
      default: return wordVal;
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (capture) rawWord <= busRdata;  // Kept for the atomic write half
  end

  // Result visible from the cycle after the read beat
  always_ff @(posedge clk) begin
    if (rst) begin
      loadData <= '0;
    end else if (capture) begin
      loadData <= extract(busRdata, hold);
    end
  end

  assign oldWord = hold.bigEndian ? lsuPkg::byteSwap(rawWord) : rawWord;

endmodule

//--- hw/lsuPkg.sv
// Widths, operation and state enums, request and bus structs, byte-order helpers
package lsuPkg;

  //////////////////////
  // Widths
  //////////////////////
  localparam int XLEN  = 32;        // Data and address width
  localparam int BYTES = XLEN / 8;  // Byte lanes per bus word

  //////////////////////
  // Encodings
  //////////////////////
  typedef enum logic [2:0] {
    opLoad,
    opStore,
    opAmoSwap,
    opAmoAdd,
    opAmoAnd,
    opAmoOr,
    opAmoXor
  } memOp_t;

  typedef enum logic [1:0] {
    sizeByte,
    sizeHalf,
    sizeWord
  } memSize_t;

  // Bus sequencer phases
  typedef enum logic [1:0] {
    stIdle,   // Waiting for a request
    stRead,   // Read beat on the bus
    stWrite,  // Write beat on the bus
    stDone    // Result strobe to the core
  } seqState_t;

  // One request from the core
  typedef struct packed {
    memOp_t            op;
    memSize_t          size;
    logic              unsignedLoad;  // Zero extend instead of sign extend
    logic              bigEndian;     // MSB at lowest address
    logic [XLEN-1:0]   addr;          // Physical byte address
    logic [XLEN-1:0]   wdata;         // Store data or atomic operand, value order
  } lsuReq_t;

  // Single-beat memory bus request
  typedef struct packed {
    logic              valid;
    logic              write;
    logic [XLEN-1:0]   addr;   // Word aligned
    logic [XLEN-1:0]   wdata;  // Lane k holds byte address k
    logic [BYTES-1:0]  wstrb;  // Lanes to write
  } busReq_t;

  // Reverse the byte lanes of a word
  function automatic logic [XLEN-1:0] byteSwap(input logic [XLEN-1:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // Read-modify-write operations
  function automatic logic isAmo(input memOp_t op);
    return op inside {opAmoSwap, opAmoAdd, opAmoAnd, opAmoOr, opAmoXor};
  endfunction

endpackage

//--- hw/lsuTop.sv
// Load/store unit top level joining the bus sequencer with the store and load data paths
`timescale 1ns/10ps

module lsuTop (
  input  logic                       clk,
  input  logic                       rst,
  // Core side
  input  logic                       reqValid,  // Single-cycle request strobe
  input  lsuPkg::lsuReq_t            req,
  output logic                       done,      // One cycle per finished request
  output logic                       fault,     // Misaligned, valid with done
  output logic                       busy,
  output logic [lsuPkg::XLEN-1:0]    loadData,
  // Memory side
  output lsuPkg::busReq_t            bus,
  input  logic                       busReady,  // Ends the current beat
  input  logic [lsuPkg::XLEN-1:0]    busRdata
);

  lsuPkg::lsuReq_t              hold;      // Accepted request
  logic                         busValid;
  logic                         busWrite;
  logic [lsuPkg::XLEN-1:0]      busAddr;
  logic                         capture;   // Read beat completes
  logic [lsuPkg::XLEN-1:0]      oldWord;   // Memory word in value order
  logic [lsuPkg::XLEN-1:0]      wdata;
  logic [lsuPkg::BYTES-1:0]     wstrb;

  busSequencer u_busSequencer (
    .clk, .rst,
    .reqValid, .req,
    .hold,
    .busValid, .busWrite, .busAddr,
    .busReady,
    .capture, .done, .fault, .busy
  );

  storeDataPath u_storeDataPath (.hold, .oldWord, .wdata, .wstrb);

  loadDataPath u_loadDataPath (
    .clk, .rst, .capture, .busRdata, .hold,
    .oldWord, .loadData
  );

  // Control fields from the sequencer, payload from the store path
  assign bus = '{valid: busValid, write: busWrite, addr: busAddr, wdata: wdata, wstrb: wstrb};

endmodule

//--- hw/storeDataPath.sv
// Store and atomic write data with lane replication, byte-order swap and byte strobes
`timescale 1ns/10ps

module storeDataPath (
  input  lsuPkg::lsuReq_t           hold,
  input  logic [lsuPkg::XLEN-1:0]   oldWord,  // Memory value for atomics, value order
  output logic [lsuPkg::XLEN-1:0]   wdata,
  output logic [lsuPkg::BYTES-1:0]  wstrb
);

  logic [lsuPkg::XLEN-1:0]  amoValue;    // op(old, wdata)
  logic [lsuPkg::XLEN-1:0]  valueWord;   // Write word before byte-order swap
  logic [1:0]               laneSel;     // Byte offset within the word
  logic                     amo;

  assign amo     = lsuPkg::isAmo(hold.op);
  assign laneSel = hold.addr[1:0];

  //////////////////////
  // Atomic ALU
  //////////////////////
  always_comb begin
    case (hold.op)
      lsuPkg::opAmoAdd: amoValue = oldWord + hold.wdata;  // Wraps modulo 2^32
      lsuPkg::opAmoAnd: amoValue = oldWord & hold.wdata;
      lsuPkg::opAmoOr:  amoValue = oldWord | hold.wdata;
      lsuPkg::opAmoXor: amoValue = oldWord ^ hold.wdata;
      default:          amoValue = hold.wdata;            // Swap
    endcase
  end

  // Replicate subword data over every lane so the strobe picks the right one
  always_comb begin
    if (amo) begin
      valueWord = amoValue;
    end else begin
      case (hold.size)
        lsuPkg::sizeByte: valueWord = {4{hold.wdata[7:0]}};
        lsuPkg::sizeHalf: valueWord = {2{hold.wdata[15:0]}};
        default:          valueWord = hold.wdata;
      endcase
    end
  end

  // Big-endian puts the MSB in the lowest addressed lane
  assign wdata = hold.bigEndian ? lsuPkg::byteSwap(valueWord) : valueWord;

  //////////////////////
  // Byte strobe
  //////////////////////
  always_comb begin
    if (amo) begin
      wstrb = 4'b1111;  // Atomics are always full word
    end else begin
      case (hold.size)
        lsuPkg::sizeByte: wstrb = 4'b0001 << laneSel;
        lsuPkg::sizeHalf: wstrb = 4'b0011 << {laneSel[1], 1'b0};
        default:          wstrb = 4'b1111;
      endcase
    end
  end

endmodule
